// ==== src/p4_pipe_pkg.sv ====
`default_nettype none

package p4_pipe_pkg;

    // ====================
    // Default sizes
    // ====================
    localparam int DEF_IN_DEPTH    = 4;
    localparam int DEF_LINK_DEPTH  = 2;
    localparam int DEF_OUT_CREDITS = 2;
    localparam int TBL_ENTRIES     = 16;

    // ====================
    // Packet and table types
    // ====================
    typedef logic [1:0] port_t;

    // Raw packet word as seen on the wire
    typedef struct packed {
        logic [7:0]  dest;
        logic [7:0]  hop;
        logic [47:0] payload;
    } pkt_word_t;

    // Decoded header, padded to 72 bits
    typedef struct packed {
        logic [7:0]  dest;
        logic [7:0]  hop;
        logic        expired;
        logic [47:0] payload;
        logic [6:0]  pad;
    } hdr_t;

    typedef struct packed {
        logic  valid;
        logic  drop;
        port_t port;
    } tbl_entry_t;

    // Execute result handed to the result stage
    typedef struct packed {
        logic [7:0]  hop;
        logic [47:0] payload;
        port_t       port;
        logic        discard;
    } act_t;

endpackage

`default_nettype wire

// ==== src/stage_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// Credit-based link between two pipeline stages
interface stage_if #(
    parameter type payload_t = logic
);

    logic     valid;
    payload_t data;
    logic     credit;

    // Sender side, spends credits
    modport producer (
        output valid,
        output data,
        input  credit
    );

    // Receiver side, returns one credit per freed slot
    modport consumer (
        input  valid,
        input  data,
        output credit
    );

endinterface

`default_nettype wire

// ==== src/ingress_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module ingress_decode #(
    parameter int IN_DEPTH   = p4_pipe_pkg::DEF_IN_DEPTH,
    parameter int LINK_DEPTH = p4_pipe_pkg::DEF_LINK_DEPTH
) (
    input  wire logic                   axil_if,
    input  wire logic                   rst_n,
    input  wire logic                   in_valid,
    input  wire p4_pipe_pkg::pkt_word_t in_data,
    output logic                        in_credit,
    stage_if.producer                   dec_out
);

    localparam int PW = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
    localparam int CW = $clog2(IN_DEPTH + 1);
    localparam int LW = $clog2(LINK_DEPTH + 1);

    p4_pipe_pkg::pkt_word_t q_mem [IN_DEPTH];
    logic [PW-1:0]          wr_ptr;
    logic [PW-1:0]          rd_ptr;
    logic [CW-1:0]          q_count;
    logic [LW-1:0]          link_cred;
    logic                   pop;
    p4_pipe_pkg::pkt_word_t head;
    p4_pipe_pkg::hdr_t      hdr;

    // ====================
    // Input queue
    // ====================
    assign head = q_mem[rd_ptr];

    // Head leaves as soon as the next stage has room
    assign pop = (q_count != '0) && (link_cred != '0);

    always_ff @(posedge axil_if) begin
        if (in_valid)
            q_mem[wr_ptr] <= in_data;
    end

    always_ff @(posedge axil_if or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            q_count   <= '0;
            link_cred <= LW'(LINK_DEPTH);
        end else begin
            if (in_valid)
                wr_ptr <= (wr_ptr == PW'(IN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PW'(IN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            q_count   <= q_count + CW'(in_valid) - CW'(pop);
            link_cred <= link_cred - LW'(pop) + LW'(dec_out.credit);
        end
    end

    // ====================
    // Field extraction
    // ====================
    always_comb begin
        hdr.dest    = head.dest;
        hdr.hop     = head.hop;
        hdr.expired = (head.hop == 8'd0);
        hdr.payload = head.payload;
        hdr.pad     = '0;
    end

    always_ff @(posedge axil_if or negedge rst_n) begin
        if (!rst_n) begin
            dec_out.valid <= 1'b0;
            in_credit     <= 1'b0;
        end else begin
            dec_out.valid <= pop;
            // One input credit back per word popped
            in_credit     <= pop;
        end
    end

    always_ff @(posedge axil_if) begin
        if (pop)
            dec_out.data <= hdr;
    end

endmodule

`default_nettype wire

// ==== src/table_execute.sv ====
`timescale 1ns/1ns
`default_nettype none

module table_execute #(
    parameter int LINK_DEPTH = p4_pipe_pkg::DEF_LINK_DEPTH
) (
    input  wire logic                    axil_if,
    input  wire logic                    rst_n,
    stage_if.consumer                    dec_in,
    stage_if.producer                    exe_out,
    input  wire logic                    reg_wr,
    input  wire logic                    reg_rd,
    input  wire logic [3:0]              reg_addr,
    input  wire p4_pipe_pkg::tbl_entry_t reg_wdata,
    output p4_pipe_pkg::tbl_entry_t      reg_rdata,
    output logic                         reg_rvalid
);

    localparam int PW = (LINK_DEPTH > 1) ? $clog2(LINK_DEPTH) : 1;
    localparam int CW = $clog2(LINK_DEPTH + 1);

    p4_pipe_pkg::tbl_entry_t tbl [p4_pipe_pkg::TBL_ENTRIES];
    p4_pipe_pkg::hdr_t       q_mem [LINK_DEPTH];
    logic [PW-1:0]           wr_ptr;
    logic [PW-1:0]           rd_ptr;
    logic [CW-1:0]           q_count;
    logic [CW-1:0]           link_cred;
    logic                    pop;
    p4_pipe_pkg::hdr_t       head;
    p4_pipe_pkg::tbl_entry_t hit;
    p4_pipe_pkg::act_t       act;

    // ====================
    // Table and register port
    // ====================
    always_ff @(posedge axil_if or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < p4_pipe_pkg::TBL_ENTRIES; i++)
                tbl[i] <= '0;
            reg_rvalid <= 1'b0;
        end else begin
            if (reg_wr)
                tbl[reg_addr] <= reg_wdata;
            reg_rvalid <= reg_rd;
        end
    end

    always_ff @(posedge axil_if) begin
        if (reg_rd)
            reg_rdata <= tbl[reg_addr];
    end

    // ====================
    // Header queue
    // ====================
    assign head = q_mem[rd_ptr];
    assign pop  = (q_count != '0) && (link_cred != '0);

    always_ff @(posedge axil_if) begin
        if (dec_in.valid)
            q_mem[wr_ptr] <= dec_in.data;
    end

    always_ff @(posedge axil_if or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            q_count   <= '0;
            link_cred <= CW'(LINK_DEPTH);
        end else begin
            if (dec_in.valid)
                wr_ptr <= (wr_ptr == PW'(LINK_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PW'(LINK_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            q_count   <= q_count + CW'(dec_in.valid) - CW'(pop);
            link_cred <= link_cred - CW'(pop) + CW'(exe_out.credit);
        end
    end

    // Lookup on low nibble of the destination code
    assign hit = tbl[head.dest[3:0]];

    always_comb begin
        act.hop     = head.hop;
        act.payload = head.payload;
        act.port    = hit.port;
        act.discard = !hit.valid || hit.drop || head.expired;
    end

    always_ff @(posedge axil_if or negedge rst_n) begin
        if (!rst_n) begin
            exe_out.valid <= 1'b0;
            dec_in.credit <= 1'b0;
        end else begin
            exe_out.valid <= pop;
            dec_in.credit <= pop;
        end
    end

    always_ff @(posedge axil_if) begin
        if (pop)
            exe_out.data <= act;
    end

endmodule

`default_nettype wire

// ==== src/egress_result.sv ====
`timescale 1ns/1ns
`default_nettype none

module egress_result #(
    parameter int LINK_DEPTH  = p4_pipe_pkg::DEF_LINK_DEPTH,
    parameter int OUT_CREDITS = p4_pipe_pkg::DEF_OUT_CREDITS
) (
    input  wire logic              axil_if,
    input  wire logic              rst_n,
    stage_if.consumer              exe_in,
    output logic                   out_valid,
    output p4_pipe_pkg::pkt_word_t out_data,
    output p4_pipe_pkg::port_t     out_port,
    input  wire logic              out_credit,
    output logic [15:0]            drop_count
);

    localparam int PW = (LINK_DEPTH > 1) ? $clog2(LINK_DEPTH) : 1;
    localparam int CW = $clog2(LINK_DEPTH + 1);
    localparam int OW = $clog2(OUT_CREDITS + 1);

    p4_pipe_pkg::act_t q_mem [LINK_DEPTH];
    logic [PW-1:0]     wr_ptr;
    logic [PW-1:0]     rd_ptr;
    logic [CW-1:0]     q_count;
    logic [OW-1:0]     out_cred;
    p4_pipe_pkg::act_t head;
    logic              q_busy;
    logic              drop_pop;
    logic              send;
    logic              pop;

    // ====================
    // Action queue
    // ====================
    assign head     = q_mem[rd_ptr];
    assign q_busy   = (q_count != '0);
    // Discards never wait, forwards need an output credit
    assign drop_pop = q_busy && head.discard;
    assign send     = q_busy && !head.discard && (out_cred != '0);
    assign pop      = drop_pop || send;

    always_ff @(posedge axil_if) begin
        if (exe_in.valid)
            q_mem[wr_ptr] <= exe_in.data;
    end

    always_ff @(posedge axil_if or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            q_count    <= '0;
            out_cred   <= OW'(OUT_CREDITS);
            drop_count <= '0;
            out_valid  <= 1'b0;
            exe_in.credit <= 1'b0;
        end else begin
            if (exe_in.valid)
                wr_ptr <= (wr_ptr == PW'(LINK_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PW'(LINK_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            q_count  <= q_count + CW'(exe_in.valid) - CW'(pop);
            out_cred <= out_cred - OW'(send) + OW'(out_credit);
            // Saturating drop counter
            if (drop_pop && (drop_count != 16'hFFFF))
                drop_count <= drop_count + 16'd1;
            out_valid     <= send;
            exe_in.credit <= pop;
        end
    end

    // ====================
    // Output word
    // ====================
    // Destination field is rewritten to the egress port number
    always_ff @(posedge axil_if) begin
        if (send) begin
            out_data.dest    <= 8'(head.port);
            out_data.hop     <= head.hop - 8'd1;
            out_data.payload <= head.payload;
            out_port         <= head.port;
        end
    end

endmodule

`default_nettype wire

// ==== src/p4_pipe.sv ====
`timescale 1ns/1ns
`default_nettype none

module p4_pipe #(
    parameter int IN_DEPTH    = p4_pipe_pkg::DEF_IN_DEPTH,
    parameter int LINK_DEPTH  = p4_pipe_pkg::DEF_LINK_DEPTH,
    parameter int OUT_CREDITS = p4_pipe_pkg::DEF_OUT_CREDITS
) (
    input  wire logic                    axil_if,
    input  wire logic                    rst_n,
    // Ingress
    input  wire logic                    in_valid,
    input  wire p4_pipe_pkg::pkt_word_t  in_data,
    output logic                         in_credit,
    // Table register port
    input  wire logic                    reg_wr,
    input  wire logic                    reg_rd,
    input  wire logic [3:0]              reg_addr,
    input  wire p4_pipe_pkg::tbl_entry_t reg_wdata,
    output p4_pipe_pkg::tbl_entry_t      reg_rdata,
    output logic                         reg_rvalid,
    // Egress
    output logic                         out_valid,
    output p4_pipe_pkg::pkt_word_t       out_data,
    output p4_pipe_pkg::port_t           out_port,
    input  wire logic                    out_credit,
    output logic [15:0]                  drop_count
);

    stage_if #(.payload_t(p4_pipe_pkg::hdr_t)) decode_to_exec ();
    stage_if #(.payload_t(p4_pipe_pkg::act_t)) exec_to_result ();

    ingress_decode #(
        .IN_DEPTH   (IN_DEPTH),
        .LINK_DEPTH (LINK_DEPTH)
    ) decode_i (
        .axil_if   (axil_if),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_credit (in_credit),
        .dec_out   (decode_to_exec.producer)
    );

    table_execute #(
        .LINK_DEPTH (LINK_DEPTH)
    ) execute_i (
        .axil_if    (axil_if),
        .rst_n      (rst_n),
        .dec_in     (decode_to_exec.consumer),
        .exe_out    (exec_to_result.producer),
        .reg_wr     (reg_wr),
        .reg_rd     (reg_rd),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .reg_rvalid (reg_rvalid)
    );

    egress_result #(
        .LINK_DEPTH  (LINK_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) result_i (
        .axil_if    (axil_if),
        .rst_n      (rst_n),
        .exe_in     (exec_to_result.consumer),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_port   (out_port),
        .out_credit (out_credit),
        .drop_count (drop_count)
    );

endmodule

`default_nettype wire

// ==== verification/tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb;

    localparam int IN_DEPTH    = p4_pipe_pkg::DEF_IN_DEPTH;
    localparam int OUT_CREDITS = p4_pipe_pkg::DEF_OUT_CREDITS;

    logic                    axil_if;
    logic                    rst_n;
    logic                    in_valid;
    p4_pipe_pkg::pkt_word_t  in_data;
    logic                    in_credit;
    logic                    reg_wr;
    logic                    reg_rd;
    logic [3:0]              reg_addr;
    p4_pipe_pkg::tbl_entry_t reg_wdata;
    p4_pipe_pkg::tbl_entry_t reg_rdata;
    logic                    reg_rvalid;
    logic                    out_valid;
    p4_pipe_pkg::pkt_word_t  out_data;
    p4_pipe_pkg::port_t      out_port;
    logic                    out_credit;
    logic [15:0]             drop_count;

    p4_pipe_pkg::tbl_entry_t tbl_m [p4_pipe_pkg::TBL_ENTRIES];
    logic [65:0]             exp_q [$];
    int    errors = 0;
    int    exp_drops = 0;
    int    in_sent = 0;
    int    in_returned = 0;
    int    outs_seen = 0;
    int    out_returned = 0;
    int    gap = 0;
    logic  hold_out = 1'b0;
    logic  rand_gap = 1'b0;
    string test_name = "reset";

    p4_pipe dut_i (
        .axil_if    (axil_if),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_credit  (in_credit),
        .reg_wr     (reg_wr),
        .reg_rd     (reg_rd),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .reg_rvalid (reg_rvalid),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_port   (out_port),
        .out_credit (out_credit),
        .drop_count (drop_count)
    );

    always #20 axil_if = ~axil_if;

    // ====================
    // Reference model
    // ====================
    // Result is {discard, port, word}, egress rewrites dest to the port number
    function automatic logic [66:0] ref_result(
        input p4_pipe_pkg::tbl_entry_t tm [p4_pipe_pkg::TBL_ENTRIES],
        input p4_pipe_pkg::pkt_word_t  w
    );
        p4_pipe_pkg::tbl_entry_t e;
        p4_pipe_pkg::pkt_word_t  o;
        logic                    discard;
        e         = tm[w.dest[3:0]];
        discard   = !e.valid || e.drop || (w.hop == 8'd0);
        o.dest    = {6'b0, e.port};
        o.hop     = w.hop - 8'd1;
        o.payload = w.payload;
        return {discard, e.port, o};
    endfunction

    // Hits entries 0..7 with a nonzero hop count
    function automatic p4_pipe_pkg::pkt_word_t fwd_word();
        p4_pipe_pkg::pkt_word_t w;
        w.dest    = {4'($urandom()), 1'b0, 3'($urandom())};
        w.hop     = 8'($urandom_range(255, 1));
        w.payload = {16'($urandom()), $urandom()};
        return w;
    endfunction

    // ====================
    // Monitors and sink
    // ====================
    always @(posedge axil_if) begin
        if (rst_n && in_credit)
            in_returned++;
    end

    always @(posedge axil_if) begin
        logic [65:0] exp_v;
        if (rst_n && out_valid) begin
            outs_seen++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("%s: output %h arrived with nothing expected", test_name, out_data);
            end else begin
                exp_v = exp_q.pop_front();
                if (out_data !== exp_v[63:0]) begin
                    errors++;
                    $display("[ERROR] %s: data expected %h, actual %h",
                             test_name, exp_v[63:0], out_data);
                end
                if (out_port !== exp_v[65:64]) begin
                    errors++;
                    $display("[ERROR] %s: port expected %0d, actual %0d",
                             test_name, exp_v[65:64], out_port);
                end
            end
        end
    end

    // Returns one output credit per word seen unless held back
    always @(posedge axil_if) begin
        #2;
        out_credit = 1'b0;
        if (rst_n && !hold_out && (outs_seen > out_returned)) begin
            if (gap > 0) begin
                gap--;
            end else begin
                out_credit = 1'b1;
                out_returned++;
                gap = rand_gap ? int'($urandom_range(3, 0)) : 0;
            end
        end
    end

    // ====================
    // Driver tasks
    // ====================
    task automatic idle(input int n);
        repeat (n) begin
            @(posedge axil_if);
            #2;
            in_valid = 1'b0;
            reg_wr   = 1'b0;
            reg_rd   = 1'b0;
        end
    endtask

    task automatic write_entry(input int addr, input p4_pipe_pkg::tbl_entry_t e);
        @(posedge axil_if);
        #2;
        reg_wr    = 1'b1;
        reg_addr  = 4'(addr);
        reg_wdata = e;
        tbl_m[addr] = e;
        @(posedge axil_if);
        #2;
        reg_wr = 1'b0;
    endtask

    task automatic read_check(input int addr);
        @(posedge axil_if);
        #2;
        reg_rd   = 1'b1;
        reg_addr = 4'(addr);
        @(posedge axil_if);
        #2;
        reg_rd = 1'b0;
        if (reg_rvalid !== 1'b1) begin
            errors++;
            $display("%s: reg_rvalid missing one cycle after read of entry %0d", test_name, addr);
        end
        if (reg_rdata !== tbl_m[addr]) begin
            errors++;
            $display("[ERROR] %s: entry %0d expected %h, actual %h",
                     test_name, addr, tbl_m[addr], reg_rdata);
        end
    endtask

    task automatic send_word(input p4_pipe_pkg::pkt_word_t w, input bit must,
                             input int limit, output bit ok);
        logic [66:0] r;
        ok = 1'b0;
        for (int t = 0; t < limit && !ok; t++) begin
            @(posedge axil_if);
            #2;
            in_valid = 1'b0;
            if (IN_DEPTH - (in_sent - in_returned) > 0) begin
                in_valid = 1'b1;
                in_data  = w;
                in_sent++;
                ok = 1'b1;
            end
        end
        if (ok) begin
            r = ref_result(tbl_m, w);
            if (r[66])
                exp_drops++;
            else
                exp_q.push_back(r[65:0]);
        end else if (must) begin
            errors++;
            $display("%s: no input credit came back within %0d cycles", test_name, limit);
        end
    endtask

    task automatic wait_drain(input int limit);
        int t;
        t = 0;
        while (!(exp_q.size() == 0 && drop_count == 16'(exp_drops)) && t < limit) begin
            @(posedge axil_if);
            #2;
            t++;
        end
        if (t >= limit) begin
            errors++;
            $display("%s: timeout, pipeline did not drain", test_name);
        end
        if (drop_count !== 16'(exp_drops)) begin
            errors++;
            $display("[ERROR] %s: drop_count expected %0d, actual %0d",
                     test_name, exp_drops, drop_count);
        end
    endtask

    // ====================
    // Test sequence
    // ====================
    initial begin
        bit ok;
        int outs0;
        int ret0;
        int ret1;
        int n_hold;
        p4_pipe_pkg::pkt_word_t w;
        void'($urandom(32'h5961));
        axil_if    = 1'b0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_data    = '0;
        reg_wr     = 1'b0;
        reg_rd     = 1'b0;
        reg_addr   = '0;
        reg_wdata  = '0;
        out_credit = 1'b0;
        for (int i = 0; i < p4_pipe_pkg::TBL_ENTRIES; i++)
            tbl_m[i] = '0;
        repeat (10) @(posedge axil_if);
        #2;
        rst_n = 1'b1;

        test_name = "table_access";
        for (int i = 0; i < p4_pipe_pkg::TBL_ENTRIES; i++)
            write_entry(i, p4_pipe_pkg::tbl_entry_t'(4'($urandom())));
        for (int i = 0; i < p4_pipe_pkg::TBL_ENTRIES; i++)
            read_check(i);

        // Entries 0..7 forward, 8..9 drop, the rest invalid
        for (int i = 0; i < p4_pipe_pkg::TBL_ENTRIES; i++)
            write_entry(i, p4_pipe_pkg::tbl_entry_t'{valid: (i < 10), drop: (i >= 8),
                                                     port: 2'(i)});

        test_name = "forwarding";
        for (int i = 0; i < 20; i++)
            send_word(fwd_word(), 1'b1, 200, ok);
        idle(1);
        wait_drain(1000);

        test_name = "dropping";
        for (int i = 0; i < 12; i++) begin
            w = fwd_word();
            case (i % 3)
                0: w.dest[3:0] = 4'(10 + (i % 6));
                1: w.dest[3:0] = 4'(8 + (i % 2));
                default: w.hop = 8'd0;
            endcase
            send_word(w, 1'b1, 200, ok);
        end
        idle(1);
        wait_drain(1000);

        test_name = "backpressure";
        @(posedge axil_if);
        hold_out = 1'b1;
        outs0  = outs_seen;
        ret0   = in_returned;
        n_hold = 0;
        for (int i = 0; i < 10 && n_hold == i; i++) begin
            send_word(fwd_word(), 1'b0, 50, ok);
            if (ok)
                n_hold++;
        end
        idle(30);
        ret1 = in_returned;
        idle(20);
        if (in_returned != ret1) begin
            errors++;
            $display("%s: in_credit kept pulsing with output credits held back", test_name);
        end
        if (in_returned - ret0 >= 10) begin
            errors++;
            $display("[ERROR] %s: in_credit pulses expected below 10, actual %0d",
                     test_name, in_returned - ret0);
        end
        if (outs_seen - outs0 > OUT_CREDITS) begin
            errors++;
            $display("[ERROR] %s: outputs expected at most %0d, actual %0d",
                     test_name, OUT_CREDITS, outs_seen - outs0);
        end
        @(posedge axil_if);
        hold_out = 1'b0;
        for (int i = n_hold; i < 10; i++)
            send_word(fwd_word(), 1'b1, 200, ok);
        idle(1);
        wait_drain(1000);
        if (outs_seen - outs0 != 10) begin
            errors++;
            $display("[ERROR] %s: outputs expected 10, actual %0d", test_name, outs_seen - outs0);
        end

        test_name = "random_traffic";
        for (int i = 0; i < p4_pipe_pkg::TBL_ENTRIES; i++)
            write_entry(i, p4_pipe_pkg::tbl_entry_t'(4'($urandom())));
        rand_gap = 1'b1;
        for (int i = 0; i < 300; i++) begin
            send_word(p4_pipe_pkg::pkt_word_t'({$urandom(), $urandom()}), 1'b1, 500, ok);
            if ($urandom_range(3, 0) == 0)
                idle(1);
        end
        idle(1);
        wait_drain(5000);
        if (exp_q.size() != 0) begin
            errors++;
            $display("[ERROR] %s: expected queue size 0, actual %0d", test_name, exp_q.size());
        end

        test_name = "input_credits";
        if (IN_DEPTH - (in_sent - in_returned) != IN_DEPTH) begin
            errors++;
            $display("[ERROR] %s: credits expected %0d, actual %0d",
                     test_name, IN_DEPTH, IN_DEPTH - (in_sent - in_returned));
        end

        $display("Words sent: %0d, outputs: %0d, drops: %0d, errors: %0d",
                 in_sent, outs_seen, exp_drops, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
src/p4_pipe_pkg.sv
src/stage_if.sv
src/ingress_decode.sv
src/table_execute.sv
src/egress_result.sv
src/p4_pipe.sv
verification/tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module tb -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
    exit 0
fi
exit 1
